// ==== Bender.yml ====
package:
  name: fp_add

sources:
  - files:
      - design/fp_add_pkg.sv
      - design/fp_add_ifs.sv
      - design/fp_add_seq.sv
      - design/fp_align.sv
      - design/fp_sum_norm.sv
      - design/fp_round.sv
      - design/fp_add_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/fp_add_tb.sv

// ==== design/fp_add_ifs.sv ====
// Stage-to-stage links of the FP adder
// Held registers, loaded on the sequencer strobes

`timescale 1ns/1ps

// Aligned operands from the align stage to the adder
interface align_if;
  logic                    sign_a;
  logic                    sign_b;          // Already flipped for subtract
  fp_add_pkg::sig_t        aligned_a;
  fp_add_pkg::sig_t        aligned_b;
  fp_add_pkg::ext_exp_t    big_exp;
  fp_add_pkg::round_mode_e rmode;
  logic                    special;
  fp_add_pkg::fp32_t       special_result;
  fp_add_pkg::fp_flags_t   special_flags;

  modport source (output sign_a, sign_b, aligned_a, aligned_b, big_exp, rmode,
                  special, special_result, special_flags);
  modport sink   (input  sign_a, sign_b, aligned_a, aligned_b, big_exp, rmode,
                  special, special_result, special_flags);
endinterface

// Normalized significand with GRS from the adder to rounding
interface norm_if;
  logic                        sign;
  fp_add_pkg::ext_exp_t        exp;
  logic [fp_add_pkg::MAN_W:0]  mant;  // 24 bits incl. hidden bit
  logic                        guard;
  logic                        round;
  logic                        sticky;
  logic                        zero;  // Exact cancellation
  fp_add_pkg::round_mode_e     rmode;
  logic                        special;
  fp_add_pkg::fp32_t           special_result;
  fp_add_pkg::fp_flags_t       special_flags;

  modport source (output sign, exp, mant, guard, round, sticky, zero, rmode,
                  special, special_result, special_flags);
  modport sink   (input  sign, exp, mant, guard, round, sticky, zero, rmode,
                  special, special_result, special_flags);
endinterface

// ==== design/fp_add_pkg.sv ====
// Single-precision FP adder shared definitions
// Format constants, datapath types, enums and the canonical NaN

package fp_add_pkg;

  // ========================================
  // Format constants
  // ========================================
  localparam int EXP_W   = 8;
  localparam int MAN_W   = 23;
  localparam int BIAS    = 127;
  localparam int EXP_MAX = 2 * BIAS + 1;  // All-ones exponent
  localparam int GRS_W   = 3;             // Guard, round, sticky

  // ========================================
  // Datapath types
  // ========================================
  typedef logic [31:0]                   fp32_t;
  typedef logic [EXP_W-1:0]              exp_t;
  typedef logic signed [EXP_W+1:0]       ext_exp_t;  // Room below 0 and above 255
  typedef logic [MAN_W+GRS_W:0]          sig_t;      // Hidden bit, fraction, GRS
  typedef logic [MAN_W+GRS_W+1:0]        sum_t;      // Plus one carry bit

  typedef struct packed {
    logic nv;  // Invalid
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } fp_flags_t;

  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } round_mode_e;

  typedef enum logic [2:0] {
    S_IDLE   = 3'd0,
    S_UNPACK = 3'd1,
    S_ALIGN  = 3'd2,
    S_ADD    = 3'd3,
    S_NORM   = 3'd4,
    S_ROUND  = 3'd5,
    S_DONE   = 3'd6
  } seq_state_e;

  // Quiet NaN, positive sign, fraction MSB set
  localparam fp32_t QNAN = 32'h7FC0_0000;

endpackage

// ==== design/fp_add_seq.sv ====
// FP adder sequencer
// Walks one operation through the stages, one state per cycle

`timescale 1ns/1ps

module fp_add_seq (
  input  logic clk,
  input  logic reset_n,
  input  logic start,
  output logic busy,
  output logic done,
  output logic unpack_en,
  output logic align_en,
  output logic add_en,
  output logic norm_en,
  output logic round_en
);

  fp_add_pkg::seq_state_e state, next_state;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n)
      state <= fp_add_pkg::S_IDLE;
    else
      state <= next_state;
  end

  always_comb begin
    case (state)
      fp_add_pkg::S_IDLE:   next_state = start ? fp_add_pkg::S_UNPACK : fp_add_pkg::S_IDLE;
      fp_add_pkg::S_UNPACK: next_state = fp_add_pkg::S_ALIGN;
      fp_add_pkg::S_ALIGN:  next_state = fp_add_pkg::S_ADD;
      fp_add_pkg::S_ADD:    next_state = fp_add_pkg::S_NORM;
      fp_add_pkg::S_NORM:   next_state = fp_add_pkg::S_ROUND;
      fp_add_pkg::S_ROUND:  next_state = fp_add_pkg::S_DONE;
      // Busy is already low here, so a new start is taken
      fp_add_pkg::S_DONE:   next_state = start ? fp_add_pkg::S_UNPACK : fp_add_pkg::S_IDLE;
      default:              next_state = fp_add_pkg::S_IDLE;
    endcase
  end

  // Strobes decode straight from the state
  assign unpack_en = (state == fp_add_pkg::S_UNPACK);
  assign align_en  = (state == fp_add_pkg::S_ALIGN);
  assign add_en    = (state == fp_add_pkg::S_ADD);
  assign norm_en   = (state == fp_add_pkg::S_NORM);
  assign round_en  = (state == fp_add_pkg::S_ROUND);

  assign busy = unpack_en | align_en | add_en | norm_en | round_en;
  assign done = (state == fp_add_pkg::S_DONE);

endmodule

// ==== design/fp_add_top.sv ====
// Single-precision FP adder/subtractor top level
// Captures the request on start and wires sequencer and stages

`timescale 1ns/1ps

module fp_add_top (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        start,
  input  logic        is_sub,
  input  logic [2:0]  rounding_mode,
  input  logic [31:0] operand_a,
  input  logic [31:0] operand_b,
  output logic        busy,
  output logic        done,
  output logic [31:0] result,
  output logic        flag_nv,
  output logic        flag_of,
  output logic        flag_uf,
  output logic        flag_nx
);

  fp_add_pkg::fp32_t       opa_q, opb_q;
  logic                    sub_q;
  fp_add_pkg::round_mode_e rm_q;
  fp_add_pkg::fp_flags_t   flags;
  logic unpack_en, align_en, add_en, norm_en, round_en;

  align_if a_if ();
  norm_if  n_if ();

  // Request is taken on the edge that accepts start
  always_ff @(posedge clk) begin
    if (start && !busy) begin
      opa_q <= operand_a;
      opb_q <= operand_b;
      sub_q <= is_sub;
      rm_q  <= fp_add_pkg::round_mode_e'(rounding_mode);
    end
  end

  fp_add_seq u_seq (
    .clk       (clk),
    .reset_n   (reset_n),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .unpack_en (unpack_en),
    .align_en  (align_en),
    .add_en    (add_en),
    .norm_en   (norm_en),
    .round_en  (round_en)
  );

  fp_align u_align (
    .clk           (clk),
    .reset_n       (reset_n),
    .operand_a     (opa_q),
    .operand_b     (opb_q),
    .is_sub        (sub_q),
    .rounding_mode (rm_q),
    .unpack_en     (unpack_en),
    .align_en      (align_en),
    .out           (a_if.source)
  );

  fp_sum_norm u_sum_norm (
    .clk     (clk),
    .reset_n (reset_n),
    .add_en  (add_en),
    .norm_en (norm_en),
    .in      (a_if.sink),
    .out     (n_if.source)
  );

  fp_round u_round (
    .clk      (clk),
    .reset_n  (reset_n),
    .round_en (round_en),
    .in       (n_if.sink),
    .result   (result),
    .flags    (flags)
  );

  assign flag_nv = flags.nv;
  assign flag_of = flags.of;
  assign flag_uf = flags.uf;
  assign flag_nx = flags.nx;

endmodule

// ==== design/fp_align.sv ====
// FP adder unpack and align stage
// Classifies both operands, resolves NaN/inf/zero cases,
// and shifts the smaller significand right with a sticky LSB

`timescale 1ns/1ps

module fp_align (
  input  logic                    clk,
  input  logic                    reset_n,
  input  fp_add_pkg::fp32_t       operand_a,
  input  fp_add_pkg::fp32_t       operand_b,
  input  logic                    is_sub,
  input  fp_add_pkg::round_mode_e rounding_mode,
  input  logic                    unpack_en,
  input  logic                    align_en,
  align_if.source                 out
);

  localparam int MAN_W = fp_add_pkg::MAN_W;

  // Unpacked operands
  fp_add_pkg::round_mode_e rmode_q;
  logic                    sign_a_q, sign_b_q;
  fp_add_pkg::exp_t        exp_a_q, exp_b_q;
  logic [MAN_W-1:0]        frac_a_q, frac_b_q;
  logic                    nan_a, nan_b, inf_a, inf_b;
  logic                    zero_a, zero_b, subn_a, subn_b;

  // Alignment datapath
  fp_add_pkg::exp_t eff_a, eff_b, diff;
  fp_add_pkg::sig_t sig_a, sig_b, small_sig, shifted, lost_mask, aligned_small;
  logic             a_big, lost, zero_sign;

  // ========================================
  // Unpack
  // ========================================
  always_ff @(posedge clk) begin
    if (unpack_en) begin
      rmode_q  <= rounding_mode;
      sign_a_q <= operand_a[31];
      sign_b_q <= operand_b[31] ^ is_sub;  // Subtract as add of -b
      exp_a_q  <= operand_a[30:MAN_W];
      exp_b_q  <= operand_b[30:MAN_W];
      frac_a_q <= operand_a[MAN_W-1:0];
      frac_b_q <= operand_b[MAN_W-1:0];
      nan_a    <= (operand_a[30:MAN_W] == fp_add_pkg::EXP_MAX) && (|operand_a[MAN_W-1:0]);
      nan_b    <= (operand_b[30:MAN_W] == fp_add_pkg::EXP_MAX) && (|operand_b[MAN_W-1:0]);
      inf_a    <= (operand_a[30:MAN_W] == fp_add_pkg::EXP_MAX) && !(|operand_a[MAN_W-1:0]);
      inf_b    <= (operand_b[30:MAN_W] == fp_add_pkg::EXP_MAX) && !(|operand_b[MAN_W-1:0]);
      zero_a   <= (operand_a[30:0] == '0);
      zero_b   <= (operand_b[30:0] == '0);
      subn_a   <= (operand_a[30:MAN_W] == '0) && (|operand_a[MAN_W-1:0]);
      subn_b   <= (operand_b[30:MAN_W] == '0) && (|operand_b[MAN_W-1:0]);
    end
  end

  // Subnormals behave as exponent 1 without hidden bit
  assign eff_a = subn_a ? 8'd1 : exp_a_q;
  assign eff_b = subn_b ? 8'd1 : exp_b_q;
  assign sig_a = {!subn_a, frac_a_q, 3'b000};
  assign sig_b = {!subn_b, frac_b_q, 3'b000};

  assign a_big     = (eff_a >= eff_b);
  assign diff      = a_big ? (eff_a - eff_b) : (eff_b - eff_a);
  assign small_sig = a_big ? sig_b : sig_a;
  assign shifted   = small_sig >> diff;  // All zero once diff >= 27

  // Everything pushed past bit 0 lands in sticky
  assign lost_mask     = ~({$bits(fp_add_pkg::sig_t){1'b1}} << diff);
  assign lost          = |(small_sig & lost_mask);
  assign aligned_small = {shifted[$bits(fp_add_pkg::sig_t)-1:1], shifted[0] | lost};

  // -0 only for two negative zeros, or either negative under RDN
  assign zero_sign = (sign_a_q & sign_b_q) |
                     ((sign_a_q | sign_b_q) & (rmode_q == fp_add_pkg::RM_RDN));

  // ========================================
  // Special cases and alignment
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      out.sign_a         <= 1'b0;
      out.sign_b         <= 1'b0;
      out.aligned_a      <= '0;
      out.aligned_b      <= '0;
      out.big_exp        <= '0;
      out.rmode          <= fp_add_pkg::RM_RNE;
      out.special        <= 1'b0;
      out.special_result <= '0;
      out.special_flags  <= '0;
    end else if (align_en) begin
      out.sign_a        <= sign_a_q;
      out.sign_b        <= sign_b_q;
      out.rmode         <= rmode_q;
      out.special       <= 1'b1;
      out.special_flags <= '0;  // Specials are exact unless invalid
      if (nan_a || nan_b || (inf_a && inf_b && (sign_a_q != sign_b_q))) begin
        out.special_result   <= fp_add_pkg::QNAN;
        out.special_flags.nv <= 1'b1;
      end else if (inf_a) begin
        out.special_result <= {sign_a_q, 8'hFF, {MAN_W{1'b0}}};
      end else if (inf_b) begin
        out.special_result <= {sign_b_q, 8'hFF, {MAN_W{1'b0}}};
      end else if (zero_a && zero_b) begin
        out.special_result <= {zero_sign, 31'b0};
      end else if (zero_a) begin
        out.special_result <= {sign_b_q, exp_b_q, frac_b_q};
      end else if (zero_b) begin
        out.special_result <= {sign_a_q, exp_a_q, frac_a_q};
      end else begin
        out.special   <= 1'b0;
        out.big_exp   <= {2'b00, (a_big ? eff_a : eff_b)};
        out.aligned_a <= a_big ? sig_a : aligned_small;
        out.aligned_b <= a_big ? aligned_small : sig_b;
      end
    end
  end

endmodule

// ==== design/fp_round.sv ====
// FP adder rounding stage
// Applies the rounding mode, catches overflow and underflow,
// and holds the final result and exception flags

`timescale 1ns/1ps

module fp_round (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  round_en,
  norm_if.sink                  in,
  output fp_add_pkg::fp32_t     result,
  output fp_add_pkg::fp_flags_t flags
);

  localparam int MAN_W = fp_add_pkg::MAN_W;

  logic                 inexact;
  logic                 up;
  logic [MAN_W+1:0]     mant_rnd;  // Extra bit for the rounding carry
  fp_add_pkg::ext_exp_t exp_rnd;

  assign inexact = in.guard | in.round | in.sticky;

  // Round-up decision
  always_comb begin
    case (in.rmode)
      fp_add_pkg::RM_RNE: up = in.guard & (in.round | in.sticky | in.mant[0]);
      fp_add_pkg::RM_RTZ: up = 1'b0;
      fp_add_pkg::RM_RDN: up = in.sign & inexact;
      fp_add_pkg::RM_RUP: up = !in.sign & inexact;
      fp_add_pkg::RM_RMM: up = in.guard;  // Ties away from zero
      default:            up = 1'b0;
    endcase
  end

  assign mant_rnd = {1'b0, in.mant} + {{(MAN_W+1){1'b0}}, up};
  // Carry bumps the exponent and leaves the fraction all zero
  assign exp_rnd  = in.exp + fp_add_pkg::ext_exp_t'(mant_rnd[MAN_W+1]);

  // ========================================
  // Result and flag registers
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result <= '0;
      flags  <= '0;
    end else if (round_en) begin
      flags <= '0;
      if (in.special) begin
        result <= in.special_result;
        flags  <= in.special_flags;
      end else if (in.zero) begin
        // Exact cancellation
        result <= {(in.rmode == fp_add_pkg::RM_RDN), 31'b0};
      end else if (exp_rnd >= fp_add_pkg::ext_exp_t'(fp_add_pkg::EXP_MAX)) begin
        result   <= {in.sign, 8'hFF, {MAN_W{1'b0}}};
        flags.of <= 1'b1;
        flags.nx <= 1'b1;
      end else if (exp_rnd <= 10'sd0) begin
        // No subnormal results so flush to signed zero
        result   <= {in.sign, 31'b0};
        flags.uf <= 1'b1;
        flags.nx <= 1'b1;
      end else begin
        result   <= {in.sign, exp_rnd[7:0], mant_rnd[MAN_W-1:0]};
        flags.nx <= inexact;
      end
    end
  end

endmodule

// ==== design/fp_sum_norm.sv ====
// FP adder magnitude add and normalize stage
// Adds or subtracts aligned significands, then normalizes with GRS

`timescale 1ns/1ps

module fp_sum_norm (
  input  logic   clk,
  input  logic   reset_n,
  input  logic   add_en,
  input  logic   norm_en,
  align_if.sink  in,
  norm_if.source out
);

  localparam int SW    = $bits(fp_add_pkg::sig_t);  // 27
  localparam int GRS_W = fp_add_pkg::GRS_W;

  fp_add_pkg::sum_t sum_q;
  logic             sign_q;
  logic [4:0]       lz;       // 0..27
  fp_add_pkg::sig_t shl;

  // ========================================
  // Magnitude add / subtract
  // ========================================
  always_ff @(posedge clk) begin
    if (add_en) begin
      if (in.sign_a == in.sign_b) begin
        sum_q  <= {1'b0, in.aligned_a} + {1'b0, in.aligned_b};
        sign_q <= in.sign_a;
      end else if (in.aligned_a >= in.aligned_b) begin
        sum_q  <= {1'b0, in.aligned_a} - {1'b0, in.aligned_b};
        sign_q <= in.sign_a;
      end else begin
        sum_q  <= {1'b0, in.aligned_b} - {1'b0, in.aligned_a};
        sign_q <= in.sign_b;  // Larger magnitude wins the sign
      end
    end
  end

  // Full leading-zero count below the carry bit
  always_comb begin
    lz = 5'd27;
    for (int i = 0; i < SW; i++) begin
      if (sum_q[i])
        lz = 5'(SW - 1 - i);
    end
  end

  assign shl = sum_q[SW-1:0] << lz;

  // ========================================
  // Normalize
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      out.sign           <= 1'b0;
      out.exp            <= '0;
      out.mant           <= '0;
      out.guard          <= 1'b0;
      out.round          <= 1'b0;
      out.sticky         <= 1'b0;
      out.zero           <= 1'b0;
      out.rmode          <= fp_add_pkg::RM_RNE;
      out.special        <= 1'b0;
      out.special_result <= '0;
      out.special_flags  <= '0;
    end else if (norm_en) begin
      out.sign           <= sign_q;
      out.zero           <= (sum_q == '0);
      out.rmode          <= in.rmode;
      out.special        <= in.special;
      out.special_result <= in.special_result;
      out.special_flags  <= in.special_flags;
      if (sum_q[SW]) begin  // Carry out needs one step right
        out.exp    <= in.big_exp + 10'sd1;
        out.mant   <= sum_q[SW:GRS_W+1];
        out.guard  <= sum_q[GRS_W];
        out.round  <= sum_q[GRS_W-1];
        out.sticky <= |sum_q[GRS_W-2:0];
      end else begin
        out.exp    <= in.big_exp - fp_add_pkg::ext_exp_t'(lz);
        out.mant   <= shl[SW-1:GRS_W];
        out.guard  <= shl[2];
        out.round  <= shl[1];
        out.sticky <= shl[0];
      end
    end
  end

endmodule

// ==== dv/fp_add_ref.svh ====
// FP adder reference model and typed compare tasks
// Wide-integer model of the single-precision add with flush-to-zero

`ifndef FP_ADD_REF_SVH
`define FP_ADD_REF_SVH

// Returns {flags, result} for a +/- b under the given rounding mode
function automatic logic [35:0] ref_fp_add(input fp_add_pkg::fp32_t a,
                                           input fp_add_pkg::fp32_t b,
                                           input logic sub,
                                           input fp_add_pkg::round_mode_e rm);
  logic                  sa, sb, sr, ts, g, rest, up, nan_a, nan_b, inf_a, inf_b;
  int                    ea, eb, er, te, d, msb;
  logic [63:0]           ma, mb, mr, tm, lost;
  logic [23:0]           mant;
  logic [24:0]           rnd;
  fp_add_pkg::fp_flags_t fl;
  sa = a[31];
  sb = b[31] ^ sub;
  ea = a[30:23];
  eb = b[30:23];
  fl = '0;
  nan_a = (ea == 255) && (a[22:0] != 0);
  nan_b = (eb == 255) && (b[22:0] != 0);
  inf_a = (ea == 255) && (a[22:0] == 0);
  inf_b = (eb == 255) && (b[22:0] == 0);
  if (nan_a || nan_b || (inf_a && inf_b && (sa != sb))) begin
    fl.nv = 1'b1;
    return {fl, fp_add_pkg::QNAN};
  end
  if (inf_a) return {fl, sa, a[30:0]};
  if (inf_b) return {fl, sb, b[30:0]};
  if (a[30:0] == 0 && b[30:0] == 0)
    return {fl, (sa & sb) | ((sa | sb) & (rm == fp_add_pkg::RM_RDN)), 31'b0};
  if (a[30:0] == 0) return {fl, sb, b[30:0]};
  if (b[30:0] == 0) return {fl, a};
  // Hidden bit at 55 with 32 spare bits below the fraction
  ma = {8'b0, (ea != 0), a[22:0], 32'b0};
  mb = {8'b0, (eb != 0), b[22:0], 32'b0};
  if (ea == 0) ea = 1;
  if (eb == 0) eb = 1;
  if (ea < eb) begin
    tm = ma;
    ma = mb;
    mb = tm;
    te = ea;
    ea = eb;
    eb = te;
    ts = sa;
    sa = sb;
    sb = ts;
  end
  d = ea - eb;
  if (d > 40) begin
    mb = (mb != 0) ? 64'd1 : 64'd0;  // Far below guard so only sticky is left
  end else begin
    lost = mb & ((64'd1 << d) - 64'd1);
    mb   = (mb >> d) | {63'b0, (lost != 0)};
  end
  if (sa == sb) begin
    mr = ma + mb;
    sr = sa;
  end else if (ma >= mb) begin
    mr = ma - mb;
    sr = sa;
  end else begin
    mr = mb - ma;
    sr = sb;
  end
  if (mr == 0) return {fl, (rm == fp_add_pkg::RM_RDN), 31'b0};
  msb = 63;
  while (!mr[msb]) msb--;
  er   = ea + msb - 55;
  mant = mr[msb -: 24];
  g    = mr[msb-24];
  rest = (mr & ((64'd1 << (msb - 24)) - 64'd1)) != 64'd0;
  case (rm)
    fp_add_pkg::RM_RNE: up = g & (rest | mant[0]);
    fp_add_pkg::RM_RDN: up = sr & (g | rest);
    fp_add_pkg::RM_RUP: up = !sr & (g | rest);
    fp_add_pkg::RM_RMM: up = g;
    default:            up = 1'b0;
  endcase
  rnd = {1'b0, mant} + {24'b0, up};
  if (rnd[24]) begin
    er  = er + 1;
    rnd = rnd >> 1;
  end
  if (er >= 255) begin
    fl.of = 1'b1;
    fl.nx = 1'b1;
    return {fl, sr, 8'hFF, 23'b0};
  end
  if (er <= 0) begin  // Flushed since results are never subnormal
    fl.uf = 1'b1;
    fl.nx = 1'b1;
    return {fl, sr, 31'b0};
  end
  fl.nx = g | rest;
  return {fl, sr, er[7:0], rnd[22:0]};
endfunction

task automatic check_word(input string name, input fp_add_pkg::fp32_t expected,
                          input fp_add_pkg::fp32_t actual);
  if (actual !== expected) begin
    value_errors++;
    $display("mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
  end
endtask

task automatic check_flags(input fp_add_pkg::fp_flags_t expected,
                           input fp_add_pkg::fp_flags_t actual);
  if (actual !== expected) begin
    value_errors++;
    $display("mismatch at %0t: flags (nv,of,uf,nx) expected %b, actual %b",
             $time, expected, actual);
  end
endtask

`endif

// ==== dv/fp_add_tb.sv ====
// Testbench for the single-precision FP adder/subtractor
// Random and directed operations, checked against a reference model

`timescale 1ns/1ps

module fp_add_tb;

  localparam int N_RANDOM    = 500;
  localparam int N_DIRECTED  = 23 * 10 + 1;  // Pairs x (add, sub) x modes, plus busy test
  localparam int WATCHDOG_NS = (N_RANDOM + N_DIRECTED) * 8 * 100 + 5 * 100;

  logic        clk, reset_n, start, is_sub, busy, done;
  logic [2:0]  rounding_mode;
  logic [31:0] operand_a, operand_b, result;
  logic        flag_nv, flag_of, flag_uf, flag_nx;

  int          value_errors  = 0;
  int          timing_errors = 0;
  int          checks        = 0;
  int          issued        = 0;
  int          completed     = 0;
  int          edge_count    = 0;
  integer      seed          = 32'h3149;
  logic [35:0] exp_q[$];    // {flags, result} per operation
  int          issue_q[$];  // Edge count at the start drive

  `include "fp_add_ref.svh"

  fp_add_top UUT (
    .clk (clk), .reset_n (reset_n), .start (start), .is_sub (is_sub),
    .rounding_mode (rounding_mode), .operand_a (operand_a), .operand_b (operand_b),
    .busy (busy), .done (done), .result (result),
    .flag_nv (flag_nv), .flag_of (flag_of), .flag_uf (flag_uf), .flag_nx (flag_nx)
  );

  always #50 clk = ~clk;

  always @(posedge clk) edge_count <= edge_count + 1;

  // ========================================
  // Stimulus helpers
  // ========================================
  task automatic issue_op(input fp_add_pkg::fp32_t a, input fp_add_pkg::fp32_t b,
                          input logic sub, input fp_add_pkg::round_mode_e rm);
    @(negedge clk);
    operand_a     = a;
    operand_b     = b;
    is_sub        = sub;
    rounding_mode = rm;
    start         = 1'b1;
    exp_q.push_back(ref_fp_add(a, b, sub, rm));
    issue_q.push_back(edge_count);
    issued++;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic run_op(input fp_add_pkg::fp32_t a, input fp_add_pkg::fp32_t b,
                        input logic sub, input fp_add_pkg::round_mode_e rm);
    issue_op(a, b, sub, rm);
    wait (completed == issued);
  endtask

  task automatic run_all_modes(input fp_add_pkg::fp32_t a, input fp_add_pkg::fp32_t b);
    for (int s = 0; s < 2; s++) begin
      for (int m = 0; m < 5; m++)
        run_op(a, b, s[0], fp_add_pkg::round_mode_e'(m));
    end
  endtask

  // Start pulse while busy must not disturb the operation in flight
  task automatic start_while_busy();
    issue_op(32'h40490FDB, 32'h3F800000, 1'b0, fp_add_pkg::RM_RNE);
    @(negedge clk);
    operand_a = 32'hC2C80000;
    operand_b = 32'h7F800000;
    is_sub    = 1'b1;
    start     = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait (completed == issued);
    repeat (3) @(negedge clk);  // Room for a stray done to show up
  endtask

  // ========================================
  // Checker
  // ========================================
  initial begin : compare
    logic [35:0]           head;
    int                    age;
    fp_add_pkg::fp_flags_t act_fl;
    forever begin
      @(negedge clk);
      if (reset_n) begin
        if (exp_q.size() == 0) begin
          if (done || busy) begin
            timing_errors++;
            $display("At %0t busy or done is high with no operation in flight", $time);
          end
        end else begin
          age = edge_count - issue_q[0];
          if (busy !== (age >= 1 && age <= 5)) begin
            timing_errors++;
            $display("At %0t busy is %b at cycle %0d after start", $time, busy, age);
          end
          if (age == 6) begin
            head   = exp_q.pop_front();
            void'(issue_q.pop_front());
            act_fl = {flag_nv, flag_of, flag_uf, flag_nx};
            if (done !== 1'b1) begin
              timing_errors++;
              $display("At %0t done did not arrive 6 cycles after start", $time);
            end else begin
              check_word("result", head[31:0], result);
              check_flags(head[35:32], act_fl);
            end
            checks++;
            completed++;
          end else if (done) begin
            timing_errors++;
            $display("At %0t done came %0d cycles after start instead of 6", $time, age);
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the DUT stopped answering", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  // ========================================
  // Main sequence
  // ========================================
  initial begin : stimulus
    logic [31:0] ra, rb, rs;
    int          ea, eb, delta;
    clk = 1'b0;
    reset_n = 1'b0;
    start = 1'b0;
    is_sub = 1'b0;
    rounding_mode = 3'd0;
    operand_a = '0;
    operand_b = '0;
    repeat (5) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    check_word("result", '0, result);  // Reset values
    check_flags('0, {flag_nv, flag_of, flag_uf, flag_nx});

    // Special operands
    run_all_modes(32'h7FC00000, 32'h3F800000);
    run_all_modes(32'h3F800000, 32'h7F800001);
    run_all_modes(32'h7F800000, 32'h7F800000);
    run_all_modes(32'hFF800000, 32'h3F800000);
    run_all_modes(32'h00000000, 32'h40600000);
    run_all_modes(32'hC0000000, 32'h80000000);
    for (int s = 0; s < 4; s++)
      run_all_modes({s[1], 31'b0}, {s[0], 31'b0});
    // Cancellation and wide exponent gaps
    run_all_modes(32'h3F800000, 32'h3F800000);
    run_all_modes(32'h3F800001, 32'h3F800000);
    run_all_modes(32'h3F800000, 32'h30800000);
    run_all_modes(32'h3F800000, 32'h33800000);  // Exact tie
    run_all_modes(32'h3F800000, 32'h33800001);
    run_all_modes(32'h7F000000, 32'h00000001);
    // Subnormals, overflow, flush to zero
    run_all_modes(32'h00400000, 32'h00400000);
    run_all_modes(32'h00000001, 32'h00800000);
    run_all_modes(32'h00400000, 32'h00000001);
    run_all_modes(32'h7F7FFFFF, 32'h7F7FFFFF);
    run_all_modes(32'h7F7FFFFF, 32'h73000000);
    run_all_modes(32'h00C00000, 32'h00800000);
    run_all_modes(32'h80800001, 32'h00800000);
    start_while_busy();

    // Random normal operands with nearby exponents
    for (int i = 0; i < N_RANDOM; i++) begin
      ra    = $random(seed);
      rb    = $random(seed);
      rs    = $random(seed);
      delta = $random(seed) % 40;
      ea    = 1 + (ra[30:23] % 254);
      eb    = ea + delta;
      if (eb < 1) eb = 1;
      if (eb > 254) eb = 254;
      run_op({ra[31], ea[7:0], ra[22:0]}, {rb[31], eb[7:0], rb[22:0]}, rs[0],
             fp_add_pkg::round_mode_e'(i % 5));
    end

    repeat (2) @(negedge clk);
    $display("Checks: %0d, value errors: %0d, timing errors: %0d",
             checks, value_errors, timing_errors);
    if (value_errors == 0 && timing_errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+dv
design/fp_add_pkg.sv
design/fp_add_ifs.sv
design/fp_add_seq.sv
design/fp_align.sv
design/fp_sum_norm.sv
design/fp_round.sv
design/fp_add_top.sv
dv/fp_add_tb.sv
